// ==== verilog/pipe_cfg_pkg.sv ====
`default_nettype none

package pipe_cfg_pkg;

	localparam int REG_W   = 32;
	localparam int RADDR_W = 5;

	typedef logic [REG_W-1:0]   reg_t;
	typedef logic [RADDR_W-1:0] raddr_t;

	// operation carried from decode to execute and memory
	typedef enum logic [3:0] {
		ALU_NOP = 4'd0,
		ALU_ADD = 4'd1,
		ALU_SUB = 4'd2,
		ALU_AND = 4'd3,
		ALU_OR  = 4'd4,
		ALU_XOR = 4'd5,
		ALU_SLT = 4'd6,
		ALU_SLL = 4'd7,
		ALU_LUI = 4'd8,
		ALU_LW  = 4'd9,
		ALU_SW  = 4'd10
	} aluop_t;

	// one bit per pipeline register
	typedef logic [3:0] stall_t;

	localparam int ST_PC    = 0;
	localparam int ST_IFID  = 1;
	localparam int ST_IDEX  = 2;
	localparam int ST_EXMEM = 3;

endpackage

`default_nettype wire

// ==== verilog/mips_isa_pkg.sv ====
`default_nettype none

package mips_isa_pkg;

	// register format: ALU ops between two registers, shifts
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fmt_t;

	// immediate format: ALU immediates, loads, stores, branches
	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} i_fmt_t;

	// one fetched word, seen through either format
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
	} inst_t;

	// primary opcodes
	localparam logic [5:0] OP_SPECIAL = 6'b000000;
	localparam logic [5:0] OP_ADDIU   = 6'b001001;
	localparam logic [5:0] OP_ORI     = 6'b001101;
	localparam logic [5:0] OP_LUI     = 6'b001111;
	localparam logic [5:0] OP_LW      = 6'b100011;
	localparam logic [5:0] OP_SW      = 6'b101011;
	localparam logic [5:0] OP_BEQ     = 6'b000100;
	localparam logic [5:0] OP_BNE     = 6'b000101;

	// function codes under OP_SPECIAL
	localparam logic [5:0] FN_ADDU = 6'b100001;
	localparam logic [5:0] FN_SUBU = 6'b100011;
	localparam logic [5:0] FN_AND  = 6'b100100;
	localparam logic [5:0] FN_OR   = 6'b100101;
	localparam logic [5:0] FN_XOR  = 6'b100110;
	localparam logic [5:0] FN_SLT  = 6'b101010;
	localparam logic [5:0] FN_SLL  = 6'b000000;

endpackage

`default_nettype wire

// ==== verilog/pipe_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// decode to execute
interface id_ex_if import pipe_cfg_pkg::*; ();
	aluop_t aluop;
	reg_t   reg1;
	reg_t   reg2;
	reg_t   store_data;
	raddr_t wd;
	logic   wreg;

	modport source (output aluop, reg1, reg2, store_data, wd, wreg);
	modport sink   (input aluop, reg1, reg2, store_data, wd, wreg);
endinterface

// execute to memory access
interface ex_mem_if import pipe_cfg_pkg::*; ();
	aluop_t aluop;
	reg_t   alu_result;
	reg_t   store_data;
	raddr_t wd;
	logic   wreg;

	modport source (output aluop, alu_result, store_data, wd, wreg);
	modport sink   (input aluop, alu_result, store_data, wd, wreg);
endinterface

// pending register write, seen by forwarding and by the register file
interface fwd_if import pipe_cfg_pkg::*; ();
	logic   wreg;
	raddr_t wd;
	reg_t   wdata;
	logic   is_load;

	modport source (output wreg, wd, wdata, is_load);
	modport sink   (input wreg, wd, wdata, is_load);
endinterface

`default_nettype wire

// ==== verilog/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import pipe_cfg_pkg::*, mips_isa_pkg::*; #(
	parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
	input  wire logic  clk,
	input  wire logic  rst_n_i,
	input  wire stall_t stall_i,
	input  wire logic  branch_taken_i,
	input  wire reg_t  branch_target_i,
	input  wire reg_t  rom_data_i,
	output reg_t       rom_addr_o,
	output logic       rom_ce_o,
	output reg_t       id_pc_o,
	output inst_t      id_inst_o
);

	// rom enable comes up one edge after reset is released
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			rom_ce_o <= 1'b0;
		end else begin
			rom_ce_o <= 1'b1;
		end
	end

	// program counter, held until the rom is enabled
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			rom_addr_o <= RESET_PC;
		end else if (rom_ce_o && !stall_i[ST_PC]) begin
			if (branch_taken_i) begin
				rom_addr_o <= branch_target_i;
			end else begin
				rom_addr_o <= rom_addr_o + 32'd4;
			end
		end
	end

	// IF/ID register, a disabled rom feeds a nop
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			id_inst_o <= '0;
		end else if (!stall_i[ST_IFID]) begin
			id_inst_o <= rom_ce_o ? inst_t'(rom_data_i) : inst_t'('0);
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_i[ST_IFID]) begin
			id_pc_o <= rom_addr_o;
		end
	end

	no_fetch_after_reset: assert property (@(posedge clk) !rst_n_i |=> !rom_ce_o);

endmodule

`default_nettype wire

// ==== verilog/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile import pipe_cfg_pkg::*; (
	input  wire logic   clk,
	input  wire logic   rst_n_i,
	fwd_if.sink         wb,
	input  wire raddr_t raddr1_i,
	input  wire raddr_t raddr2_i,
	output reg_t        rdata1_o,
	output reg_t        rdata2_o
);

	reg_t regs [32];

	// register zero is never written
	always_ff @(posedge clk) begin
		if (rst_n_i && wb.wreg && wb.wd != '0) begin
			regs[wb.wd] <= wb.wdata;
		end
	end

	// same-cycle write is returned to the reader
	always_comb begin
		if (raddr1_i == '0) begin
			rdata1_o = '0;
		end else if (wb.wreg && wb.wd == raddr1_i) begin
			rdata1_o = wb.wdata;
		end else begin
			rdata1_o = regs[raddr1_i];
		end
	end

	always_comb begin
		if (raddr2_i == '0) begin
			rdata2_o = '0;
		end else if (wb.wreg && wb.wd == raddr2_i) begin
			rdata2_o = wb.wdata;
		end else begin
			rdata2_o = regs[raddr2_i];
		end
	end

	zero_read1: assert property (@(posedge clk) raddr1_i == '0 |-> rdata1_o == '0);
	zero_read2: assert property (@(posedge clk) raddr2_i == '0 |-> rdata2_o == '0);

endmodule

`default_nettype wire

// ==== verilog/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage import pipe_cfg_pkg::*, mips_isa_pkg::*; (
	input  wire logic   clk,
	input  wire logic   rst_n_i,
	input  wire stall_t stall_i,
	input  wire reg_t   pc_i,
	input  wire inst_t  inst_i,
	input  wire reg_t   rdata1_i,
	input  wire reg_t   rdata2_i,
	output raddr_t      raddr1_o,
	output raddr_t      raddr2_o,
	fwd_if.sink         ex_fwd,
	fwd_if.sink         mem_fwd,
	id_ex_if.source     id_ex,
	output logic        branch_taken_o,
	output reg_t        branch_target_o,
	output logic        stallreq_o
);

	aluop_t aluop;
	raddr_t wd;
	logic   wreg;
	logic   re1;
	logic   re2;
	logic   use_imm;
	logic   use_shamt;
	reg_t   imm;
	reg_t   imm_sext;
	reg_t   imm_zext;
	reg_t   op1;
	reg_t   op2;
	logic   ex_hit1;
	logic   ex_hit2;
	logic   mem_hit1;
	logic   mem_hit2;
	logic   cond_met;

	assign imm_sext = {{16{inst_i.i_fmt.imm[15]}}, inst_i.i_fmt.imm};
	assign imm_zext = {16'h0000, inst_i.i_fmt.imm};
	assign raddr1_o = inst_i.i_fmt.rs;
	assign raddr2_o = inst_i.i_fmt.rt;

	always_comb begin
		aluop = ALU_NOP;
		wd = inst_i.i_fmt.rt;
		wreg = 1'b0;
		re1 = 1'b0;
		re2 = 1'b0;
		use_imm = 1'b1;
		use_shamt = 1'b0;
		imm = imm_sext;
		case (inst_i.i_fmt.opcode)
			OP_SPECIAL: begin
				wd = inst_i.r_fmt.rd;
				wreg = 1'b1;
				re1 = 1'b1;
				re2 = 1'b1;
				use_imm = 1'b0;
				case (inst_i.r_fmt.funct)
					FN_ADDU: aluop = ALU_ADD;
					FN_SUBU: aluop = ALU_SUB;
					FN_AND:  aluop = ALU_AND;
					FN_OR:   aluop = ALU_OR;
					FN_XOR:  aluop = ALU_XOR;
					FN_SLT:  aluop = ALU_SLT;
					FN_SLL: begin
						// shift amount replaces rs
						aluop = ALU_SLL;
						re1 = 1'b0;
						use_shamt = 1'b1;
					end
					default: begin
						wreg = 1'b0;
						re1 = 1'b0;
						re2 = 1'b0;
					end
				endcase
			end
			OP_ADDIU: begin
				aluop = ALU_ADD;
				wreg = 1'b1;
				re1 = 1'b1;
			end
			OP_ORI: begin
				aluop = ALU_OR;
				wreg = 1'b1;
				re1 = 1'b1;
				imm = imm_zext;
			end
			OP_LUI: begin
				aluop = ALU_LUI;
				wreg = 1'b1;
				imm = imm_zext;
			end
			OP_LW: begin
				aluop = ALU_LW;
				wreg = 1'b1;
				re1 = 1'b1;
			end
			OP_SW: begin
				aluop = ALU_SW;
				re1 = 1'b1;
				re2 = 1'b1;
			end
			OP_BEQ, OP_BNE: begin
				re1 = 1'b1;
				re2 = 1'b1;
			end
			default: aluop = ALU_NOP;
		endcase
	end

	// execute result wins over memory result
	assign ex_hit1 = ex_fwd.wreg && ex_fwd.wd == inst_i.i_fmt.rs;
	assign ex_hit2 = ex_fwd.wreg && ex_fwd.wd == inst_i.i_fmt.rt;
	assign mem_hit1 = mem_fwd.wreg && mem_fwd.wd == inst_i.i_fmt.rs;
	assign mem_hit2 = mem_fwd.wreg && mem_fwd.wd == inst_i.i_fmt.rt;

	assign op1 = ex_hit1 ? ex_fwd.wdata : (mem_hit1 ? mem_fwd.wdata : rdata1_i);
	assign op2 = ex_hit2 ? ex_fwd.wdata : (mem_hit2 ? mem_fwd.wdata : rdata2_i);

	// load result not ready until memory stage
	assign stallreq_o = ex_fwd.is_load && ((re1 && ex_hit1) || (re2 && ex_hit2));

	assign cond_met = (inst_i.i_fmt.opcode == OP_BEQ && op1 == op2) ||
		(inst_i.i_fmt.opcode == OP_BNE && op1 != op2);
	// no redirect while the PC is held
	assign branch_taken_o = cond_met && !stall_i[ST_PC];
	// target is relative to the delay slot
	assign branch_target_o = pc_i + 32'd4 + {imm_sext[29:0], 2'b00};

	// ID/EX register takes a bubble on load-use
	always_ff @(posedge clk) begin
		if (!rst_n_i || stall_i[ST_IDEX]) begin
			id_ex.aluop <= ALU_NOP;
			id_ex.wreg <= 1'b0;
			id_ex.wd <= '0;
		end else begin
			id_ex.aluop <= aluop;
			id_ex.wreg <= wreg && wd != '0;
			id_ex.wd <= wd;
		end
		id_ex.reg1 <= use_shamt ? reg_t'(inst_i.r_fmt.shamt) : op1;
		id_ex.reg2 <= use_imm ? imm : op2;
		id_ex.store_data <= op2;
	end

	no_branch_on_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
		!(branch_taken_o && stallreq_o));

endmodule

`default_nettype wire

// ==== verilog/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage import pipe_cfg_pkg::*; (
	input  wire logic clk,
	input  wire logic rst_n_i,
	id_ex_if.sink     id_ex,
	ex_mem_if.source  ex_mem,
	fwd_if.source     ex_fwd
);

	reg_t result;

	always_comb begin
		case (id_ex.aluop)
			ALU_ADD: result = id_ex.reg1 + id_ex.reg2;
			ALU_SUB: result = id_ex.reg1 - id_ex.reg2;
			ALU_AND: result = id_ex.reg1 & id_ex.reg2;
			ALU_OR:  result = id_ex.reg1 | id_ex.reg2;
			ALU_XOR: result = id_ex.reg1 ^ id_ex.reg2;
			ALU_SLT: result = reg_t'($signed(id_ex.reg1) < $signed(id_ex.reg2));
			ALU_SLL: result = id_ex.reg2 << id_ex.reg1[4:0];
			ALU_LUI: result = {id_ex.reg2[15:0], 16'h0000};
			// effective address for loads and stores
			ALU_LW, ALU_SW: result = id_ex.reg1 + id_ex.reg2;
			default: result = '0;
		endcase
	end

	// unregistered result for decode forwarding
	assign ex_fwd.wreg = id_ex.wreg;
	assign ex_fwd.wd = id_ex.wd;
	assign ex_fwd.wdata = result;
	assign ex_fwd.is_load = id_ex.aluop == ALU_LW;

	// EX/MEM register
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			ex_mem.aluop <= ALU_NOP;
			ex_mem.wreg <= 1'b0;
			ex_mem.wd <= '0;
		end else begin
			ex_mem.aluop <= id_ex.aluop;
			ex_mem.wreg <= id_ex.wreg;
			ex_mem.wd <= id_ex.wd;
		end
		ex_mem.alu_result <= result;
		ex_mem.store_data <= id_ex.store_data;
	end

endmodule

`default_nettype wire

// ==== verilog/mem_access_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_access_stage import pipe_cfg_pkg::*; (
	input  wire logic clk,
	input  wire logic rst_n_i,
	ex_mem_if.sink    ex_mem,
	input  wire reg_t ram_data_i,
	output reg_t      ram_addr_o,
	output reg_t      ram_data_o,
	output logic      ram_we_o,
	output logic [3:0] ram_sel_o,
	output logic      ram_ce_o,
	fwd_if.source     mem_fwd,
	fwd_if.source     wb_fwd
);

	logic is_lw;
	logic is_sw;
	reg_t result;

	assign is_lw = ex_mem.aluop == ALU_LW;
	assign is_sw = ex_mem.aluop == ALU_SW;

	// word accesses only
	assign ram_ce_o = is_lw || is_sw;
	assign ram_we_o = is_sw;
	assign ram_sel_o = ram_ce_o ? 4'b1111 : 4'b0000;
	assign ram_addr_o = ex_mem.alu_result;
	assign ram_data_o = ex_mem.store_data;

	assign result = is_lw ? ram_data_i : ex_mem.alu_result;

	assign mem_fwd.wreg = ex_mem.wreg;
	assign mem_fwd.wd = ex_mem.wd;
	assign mem_fwd.wdata = result;
	assign mem_fwd.is_load = is_lw;

	// MEM/WB register
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			wb_fwd.wreg <= 1'b0;
			wb_fwd.wd <= '0;
			wb_fwd.is_load <= 1'b0;
		end else begin
			wb_fwd.wreg <= ex_mem.wreg;
			wb_fwd.wd <= ex_mem.wd;
			wb_fwd.is_load <= is_lw;
		end
		wb_fwd.wdata <= result;
	end

	we_needs_ce: assert property (@(posedge clk) ram_we_o |-> ram_ce_o);

endmodule

`default_nettype wire

// ==== verilog/pipe_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl import pipe_cfg_pkg::*; (
	input  wire logic clk,
	input  wire logic rst_n_i,
	input  wire logic stallreq_i,
	output stall_t    stall_o
);

	// decode stall: hold front end, bubble into execute
	always_comb begin
		stall_o = '0;
		stall_o[ST_PC] = stallreq_i;
		stall_o[ST_IFID] = stallreq_i;
		stall_o[ST_IDEX] = stallreq_i;
		// memory side never waits
		stall_o[ST_EXMEM] = 1'b0;
	end

	// the bubble must clear the load-use hazard in one cycle
	single_cycle_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
		stallreq_i |=> !stallreq_i);

endmodule

`default_nettype wire

// ==== verilog/openmips.sv ====
`timescale 1ns/1ps
`default_nettype none

module openmips import pipe_cfg_pkg::*, mips_isa_pkg::*; #(
	parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
	input  wire logic  clk,
	input  wire logic  rst_n_i,
	input  wire reg_t  rom_data_i,
	output reg_t       rom_addr_o,
	output logic       rom_ce_o,
	input  wire reg_t  ram_data_i,
	output reg_t       ram_addr_o,
	output reg_t       ram_data_o,
	output logic       ram_we_o,
	output logic [3:0] ram_sel_o,
	output logic       ram_ce_o
);

	stall_t stall;
	logic   stallreq;
	logic   branch_taken;
	reg_t   branch_target;
	reg_t   id_pc;
	inst_t  id_inst;
	raddr_t raddr1;
	raddr_t raddr2;
	reg_t   rdata1;
	reg_t   rdata2;

	id_ex_if  id_ex ();
	ex_mem_if ex_mem ();
	fwd_if    ex_fwd ();
	fwd_if    mem_fwd ();
	fwd_if    wb_fwd ();

	fetch_stage #(
		.RESET_PC(RESET_PC)
	) fetch0 (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.stall_i(stall),
		.branch_taken_i(branch_taken),
		.branch_target_i(branch_target),
		.rom_data_i(rom_data_i),
		.rom_addr_o(rom_addr_o),
		.rom_ce_o(rom_ce_o),
		.id_pc_o(id_pc),
		.id_inst_o(id_inst)
	);

	// write port fed from MEM/WB
	regfile regfile0 (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.wb(wb_fwd.sink),
		.raddr1_i(raddr1),
		.raddr2_i(raddr2),
		.rdata1_o(rdata1),
		.rdata2_o(rdata2)
	);

	decode_stage decode0 (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.stall_i(stall),
		.pc_i(id_pc),
		.inst_i(id_inst),
		.rdata1_i(rdata1),
		.rdata2_i(rdata2),
		.raddr1_o(raddr1),
		.raddr2_o(raddr2),
		.ex_fwd(ex_fwd.sink),
		.mem_fwd(mem_fwd.sink),
		.id_ex(id_ex.source),
		.branch_taken_o(branch_taken),
		.branch_target_o(branch_target),
		.stallreq_o(stallreq)
	);

	execute_stage execute0 (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.id_ex(id_ex.sink),
		.ex_mem(ex_mem.source),
		.ex_fwd(ex_fwd.source)
	);

	mem_access_stage mem0 (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.ex_mem(ex_mem.sink),
		.ram_data_i(ram_data_i),
		.ram_addr_o(ram_addr_o),
		.ram_data_o(ram_data_o),
		.ram_we_o(ram_we_o),
		.ram_sel_o(ram_sel_o),
		.ram_ce_o(ram_ce_o),
		.mem_fwd(mem_fwd.source),
		.wb_fwd(wb_fwd.source)
	);

	pipe_ctrl ctrl0 (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.stallreq_i(stallreq),
		.stall_o(stall)
	);

endmodule

`default_nettype wire

// ==== test/openmips_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module openmips_tb import pipe_cfg_pkg::*; ();

	localparam logic [31:0] RESET_PC = 32'h0000_0000;

	logic       clk;
	logic       rst_n_i;
	reg_t       rom_data_i;
	reg_t       rom_addr_o;
	logic       rom_ce_o;
	reg_t       ram_data_i;
	reg_t       ram_addr_o;
	reg_t       ram_data_o;
	logic       ram_we_o;
	logic [3:0] ram_sel_o;
	logic       ram_ce_o;

	reg_t rom [0:255];
	reg_t ram [0:255];
	reg_t exp_addr [0:63];
	reg_t exp_data [0:63];
	int   rom_words;
	int   n_stores;
	int   store_idx;
	int   cycles;
	int   limit;
	logic fetch_seen;

	openmips #(
		.RESET_PC(RESET_PC)
	) dut_i (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.rom_data_i(rom_data_i),
		.rom_addr_o(rom_addr_o),
		.rom_ce_o(rom_ce_o),
		.ram_data_i(ram_data_i),
		.ram_addr_o(ram_addr_o),
		.ram_data_o(ram_data_o),
		.ram_we_o(ram_we_o),
		.ram_sel_o(ram_sel_o),
		.ram_ce_o(ram_ce_o)
	);

	task automatic report_mismatch(input string name, input reg_t got, input reg_t expected);
		$display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, expected);
		$display("Simulation failed");
		$fatal(1, "value mismatch on %s", name);
	endtask

	task automatic stop_on_error(input string msg);
		$display("error at t=%0t: %s", $time, msg);
		$display("Simulation failed");
		$fatal(1, "%s", msg);
	endtask

	// tag I is a program word, tag S an expected store, # starts a comment
	task automatic load_testdata();
		int fd;
		int n;
		logic [7:0] tag;
		reg_t word;
		reg_t addr;
		logic [8*160-1:0] rest;
		logic done;
		fd = $fopen("test/openmips_testdata.txt", "r");
		if (fd == 0) begin
			stop_on_error("cannot open test/openmips_testdata.txt");
		end
		done = 1'b0;
		while (!done) begin
			n = $fscanf(fd, " %c", tag);
			if (n != 1) begin
				done = 1'b1;
			end else if (tag == "#") begin
				n = $fgets(rest, fd);
			end else if (tag == "I") begin
				n = $fscanf(fd, " %h", word);
				if (n != 1 || rom_words == 256) begin
					stop_on_error("bad or too many program words in test data");
				end
				rom[rom_words[7:0]] = word;
				rom_words++;
			end else if (tag == "S") begin
				n = $fscanf(fd, " %h %h", addr, word);
				if (n != 2 || n_stores == 64) begin
					stop_on_error("bad or too many expected stores in test data");
				end
				exp_addr[n_stores[5:0]] = addr;
				exp_data[n_stores[5:0]] = word;
				n_stores++;
			end else begin
				stop_on_error("unknown line tag in test data");
			end
		end
		$fclose(fd);
		if (rom_words == 0 || n_stores == 0) begin
			stop_on_error("test data holds no program or no expected stores");
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// memory models answer within the cycle and change on the falling edge
	always @(negedge clk) begin
		if (rom_ce_o && !fetch_seen) begin
			assert (rom_addr_o == RESET_PC)
				else report_mismatch("rom_addr_o", rom_addr_o, RESET_PC);
			fetch_seen = 1'b1;
		end
		if (ram_we_o) begin
			assert (store_idx < n_stores)
				else stop_on_error("store seen after the last expected one");
			assert (ram_ce_o)
				else report_mismatch("ram_ce_o", 32'(ram_ce_o), 32'h1);
			assert (ram_sel_o == 4'hf)
				else report_mismatch("ram_sel_o", 32'(ram_sel_o), 32'hf);
			assert (ram_addr_o == exp_addr[store_idx[5:0]])
				else report_mismatch("ram_addr_o", ram_addr_o, exp_addr[store_idx[5:0]]);
			assert (ram_data_o == exp_data[store_idx[5:0]])
				else report_mismatch("ram_data_o", ram_data_o, exp_data[store_idx[5:0]]);
			ram[ram_addr_o[9:2]] = ram_data_o;
			store_idx++;
		end
		rom_data_i = rom[rom_addr_o[9:2]];
		ram_data_i = ram[ram_addr_o[9:2]];
	end

	initial begin
		rst_n_i = 1'b0;
		rom_data_i = '0;
		ram_data_i = '0;
		rom_words = 0;
		n_stores = 0;
		store_idx = 0;
		cycles = 0;
		fetch_seen = 1'b0;
		for (int i = 0; i < 256; i++) begin
			rom[i[7:0]] = '0;
			// background differs for every byte address
			ram[i[7:0]] = ~(i * 4);
		end
		load_testdata();
		limit = 4 * rom_words + 50;

		// one rising edge in reset per pass, checked after it
		repeat (3) begin
			@(posedge clk);
			@(negedge clk);
			assert (!rom_ce_o)
				else report_mismatch("rom_ce_o", 32'(rom_ce_o), 32'h0);
			assert (!ram_ce_o)
				else report_mismatch("ram_ce_o", 32'(ram_ce_o), 32'h0);
			assert (!ram_we_o)
				else report_mismatch("ram_we_o", 32'(ram_we_o), 32'h0);
		end
		rst_n_i = 1'b1;

		while (store_idx < n_stores && cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		if (store_idx == n_stores) begin
			// a few more cycles so a stray store would still be caught
			repeat (8) @(posedge clk);
			$display("Simulation passed");
			$finish;
		end else begin
			$display("timeout after %0d cycles, %0d of %0d stores seen",
				cycles, store_idx, n_stores);
			$display("Simulation failed");
			$fatal(1, "timeout");
		end
	end

endmodule

`default_nettype wire

// ==== test/openmips_testdata.txt ====
# I <word>: program word in hex, loaded from address 0 upward
# S <addr> <data>: expected data RAM store in hex, in program order
I 3C011234  # lui   r1, 0x1234
I 34215678  # ori   r1, r1, 0x5678
I 24020100  # addiu r2, r0, 0x100
I AC410000  # sw    r1, 0(r2)
I 2403FFFB  # addiu r3, r0, -5
I 24040007  # addiu r4, r0, 7
I 00642821  # addu  r5, r3, r4
I 00643023  # subu  r6, r3, r4
I AC450004  # sw    r5, 4(r2)
I AC460008  # sw    r6, 8(r2)
I 00263824  # and   r7, r1, r6
I 00C14025  # or    r8, r6, r1
I 00284826  # xor   r9, r1, r8
I AC47000C  # sw    r7, 12(r2)
I AC480010  # sw    r8, 16(r2)
I AC490014  # sw    r9, 20(r2)
I 0064502A  # slt   r10, r3, r4
I 0083582A  # slt   r11, r4, r3
I 00046100  # sll   r12, r4, 4
I AC4A0018  # sw    r10, 24(r2)
I AC4B001C  # sw    r11, 28(r2)
I AC4C0020  # sw    r12, 32(r2)
I 8C4D0000  # lw    r13, 0(r2)
I 01A57021  # addu  r14, r13, r5  (load-use)
I AC4E0024  # sw    r14, 36(r2)
I 10840002  # beq   r4, r4, +2  (taken)
I 240F0055  # addiu r15, r0, 0x55  (delay slot)
I 240F0099  # addiu r15, r0, 0x99  (skipped)
I AC4F0028  # sw    r15, 40(r2)
I 14840002  # bne   r4, r4, +2  (not taken)
I 24100066  # addiu r16, r0, 0x66  (delay slot)
I 26100001  # addiu r16, r16, 1
I AC50002C  # sw    r16, 44(r2)
I 24000077  # addiu r0, r0, 0x77
I 00210021  # addu  r0, r1, r1
I AC400030  # sw    r0, 48(r2)
S 00000100 12345678
S 00000104 00000002
S 00000108 FFFFFFF4
S 0000010C 12345670
S 00000110 FFFFFFFC
S 00000114 EDCBA984
S 00000118 00000001
S 0000011C 00000000
S 00000120 00000070
S 00000124 1234567A
S 00000128 00000055
S 0000012C 00000067
S 00000130 00000000

// ==== src.f ====
verilog/pipe_cfg_pkg.sv
verilog/mips_isa_pkg.sv
verilog/pipe_if.sv
verilog/fetch_stage.sv
verilog/regfile.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/mem_access_stage.sv
verilog/pipe_ctrl.sv
verilog/openmips.sv
test/openmips_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module openmips_tb -o openmips_sim

# exit status follows the search for the pass line
./obj_dir/openmips_sim 2>&1 | tee /dev/stderr | grep -x "Simulation passed" > /dev/null
